//--- common/soc_map_pkg.sv
// Peripheral address map
package soc_map_pkg;

  ////////////////////////////////////////
  // slot field
  ////////////////////////////////////////

  localparam int N_SLOTS  = 16;  // one-hot selects
  localparam int SLOT_LSB = 20;  // addr[23:20]
  localparam int SLOT_W   = 4;
  localparam int IDX_LSB  = 2;   // word aligned
  localparam int IDX_W    = 5;   // addr[6:2]

  ////////////////////////////////////////
  // slot numbers
  ////////////////////////////////////////

  localparam int SLOT_UART = 2;
  localparam int SLOT_SD   = 6;
  localparam int SLOT_GPIO = 7;  // leds and dip switches

  ////////////////////////////////////////
  // register indexes
  ////////////////////////////////////////

  localparam int UART_TX_IDX   = 0;   // byte plus transmit strobe
  localparam int UART_BAUD_IDX = 1;

  localparam int SD_WR_LAST    = 10;  // writable bank is 0..10
  localparam int SD_DETECT_IDX = 12;
  localparam int SD_RB_BASE    = 16;  // read-back copies at 16..26

  // returned for any SD index with nothing behind it
  localparam logic [31:0] UNMAPPED_WORD = 32'hDEAD_BEEF;

endpackage

//--- common/periph_types_pkg.sv
// Peripheral register types
package periph_types_pkg;

  ////////////////////////////////////////
  // bus side
  ////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [15:0] slot_vec_t;  // one bit per slot
  typedef logic [4:0]  reg_idx_t;

  ////////////////////////////////////////
  // gpio and uart
  ////////////////////////////////////////

  typedef logic [7:0]  led_t;
  typedef logic [15:0] dip_t;
  typedef logic [15:0] baud_t;  // clocks per bit

  localparam baud_t BAUD_RESET = 16'd87;

  ////////////////////////////////////////
  // sd control fields
  ////////////////////////////////////////

  typedef logic [1:0]  sd_align_t;
  typedef logic [15:0] sd_clk_cfg_t;
  typedef logic [5:0]  sd_cmd_idx_t;
  typedef logic [2:0]  sd_setting_t;  // data start and cmd setting
  typedef logic [15:0] sd_blkcnt_t;
  typedef logic [11:0] sd_blksize_t;

  // {dwe, den, addr[6:0]} of the clock reconfiguration port
  typedef logic [8:0]  sd_drp_t;

  // {sd_reset, clk_rst, data_rst, cmd_rst}
  typedef logic [3:0]  sd_resets_t;

endpackage

//--- common/periph_bus_if.sv
// Decoded peripheral bus
`timescale 1ns/1ps

interface periph_bus_if
  import periph_types_pkg::*;
  ();

  word_t     wdata;     // write data, straight from the master
  reg_idx_t  reg_idx;   // register inside the slot
  slot_vec_t slot_sel;  // addressed slot, every cycle
  slot_vec_t slot_we;   // slot_sel qualified by the strobe

  modport decoder (
    output wdata,
    output reg_idx,
    output slot_sel,
    output slot_we
  );

  modport target (
    input wdata,
    input reg_idx,
    input slot_we
  );

  modport reader (
    input slot_sel
  );

endinterface

//--- source/bus_decode.sv
// Address and strobe decode
`timescale 1ns/1ps

module bus_decode
  import soc_map_pkg::*;
  import periph_types_pkg::*;
(
  input  word_t        bus_addr_i,
  input  logic         bus_we_i,
  input  word_t        bus_wdata_i,
  periph_bus_if.decoder bus
);

  logic [SLOT_W-1:0] slot_field;

  assign slot_field = bus_addr_i[SLOT_LSB +: SLOT_W];  // addr[23:20]

  ////////////////////////////////////////
  // slot selects
  ////////////////////////////////////////

  always_comb
  begin
    bus.slot_sel = '0;
    for (int i = 0; i < N_SLOTS; i++)
    begin
      bus.slot_sel[i] = (slot_field == i);
    end
  end

  assign bus.slot_we = bus.slot_sel & {N_SLOTS{bus_we_i}};  // write only

  ////////////////////////////////////////
  // index and data
  ////////////////////////////////////////

  assign bus.reg_idx = bus_addr_i[IDX_LSB +: IDX_W];  // addr[6:2]
  assign bus.wdata   = bus_wdata_i;

  // at most one register block may see a write in any cycle
  slot_we_onehot0: assert final ($onehot0(bus.slot_we))
    else $error("slot_we has more than one bit set: %h", bus.slot_we);

endmodule

//--- source/misc_regs.sv
// LED, switch and UART control registers
`timescale 1ns/1ps

module misc_regs
  import soc_map_pkg::*;
  import periph_types_pkg::*;
(
  input  logic         msoc_clk,
  input  logic         rstn,
  periph_bus_if.target bus,
  input  dip_t         dip_i,
  output led_t         led_o,
  output logic         uart_tx_start_o,
  output logic [7:0]   uart_tx_byte_o,
  output baud_t        uart_baud_o,
  output word_t        gpio_rdata_o
);

  dip_t dip_q;
  logic tx_wr;
  logic baud_wr;

  assign tx_wr   = bus.slot_we[SLOT_UART] && (bus.reg_idx == UART_TX_IDX);
  assign baud_wr = bus.slot_we[SLOT_UART] && (bus.reg_idx == UART_BAUD_IDX);

  ////////////////////////////////////////
  // gpio slot
  ////////////////////////////////////////

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      led_o <= '0;
      dip_q <= '0;
    end
    else
    begin
      dip_q <= dip_i;  // sampled every clock
      if (bus.slot_we[SLOT_GPIO])
        led_o <= bus.wdata[$bits(led_t)-1:0];
    end
  end

  assign gpio_rdata_o = word_t'(dip_q);  // zero-extended

  ////////////////////////////////////////
  // uart transmit control
  ////////////////////////////////////////

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      uart_tx_start_o <= 1'b0;
      uart_tx_byte_o  <= '0;
      uart_baud_o     <= BAUD_RESET;
    end
    else
    begin
      uart_tx_start_o <= tx_wr;  // self-clearing
      if (tx_wr)
        uart_tx_byte_o <= bus.wdata[7:0];
      if (baud_wr)
        uart_baud_o <= bus.wdata[$bits(baud_t)-1:0];
    end
  end

  // transmit strobe is a single-cycle pulse
  tx_strobe_single: assert property (
    @(posedge msoc_clk) disable iff (!rstn)
    uart_tx_start_o |=> !uart_tx_start_o
  ) else $error("uart_tx_start_o held for two cycles");

endmodule

//--- sd_ctrl/sd_ctrl_regs.sv
// SD card control register bank
`timescale 1ns/1ps

module sd_ctrl_regs
  import soc_map_pkg::*;
  import periph_types_pkg::*;
(
  input  logic         msoc_clk,
  input  logic         rstn,
  periph_bus_if.target bus,
  input  logic         sd_detect_i,
  output word_t        sd_rdata_o,
  output sd_align_t    sd_align_o,
  output sd_clk_cfg_t  sd_clk_cfg_o,
  output word_t        sd_cmd_arg_o,
  output sd_cmd_idx_t  sd_cmd_idx_o,
  output sd_setting_t  sd_data_start_o,
  output sd_setting_t  sd_cmd_setting_o,
  output logic         sd_cmd_start_o,
  output sd_resets_t   sd_resets_o,
  output sd_blkcnt_t   sd_blkcnt_o,
  output sd_blksize_t  sd_blksize_o,
  output word_t        sd_cmd_timeout_o,
  output sd_drp_t      sd_drp_o
);

  logic detect_q;
  logic bank_we;

  assign bank_we = bus.slot_we[SLOT_SD];

  ////////////////////////////////////////
  // writable bank, index 0..10
  ////////////////////////////////////////

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      sd_align_o       <= '0;
      sd_clk_cfg_o     <= '0;
      sd_cmd_arg_o     <= '0;
      sd_cmd_idx_o     <= '0;
      sd_data_start_o  <= '0;
      sd_cmd_setting_o <= '0;
      sd_cmd_start_o   <= 1'b0;
      sd_resets_o      <= '0;
      sd_blkcnt_o      <= '0;
      sd_blksize_o     <= '0;
      sd_cmd_timeout_o <= '0;
      sd_drp_o         <= '0;
      detect_q         <= 1'b0;
    end
    else
    begin
      detect_q <= sd_detect_i;  // card detect, sampled every clock
      if (bank_we)
      begin
        case (bus.reg_idx)
          5'd0:  sd_align_o       <= bus.wdata[1:0];
          5'd1:  sd_clk_cfg_o     <= bus.wdata[15:0];
          5'd2:  sd_cmd_arg_o     <= bus.wdata;
          5'd3:  sd_cmd_idx_o     <= bus.wdata[5:0];
          5'd4:
          begin
            sd_data_start_o  <= bus.wdata[5:3];
            sd_cmd_setting_o <= bus.wdata[2:0];
          end
          5'd5:  sd_cmd_start_o   <= bus.wdata[0];
          5'd6:  sd_resets_o      <= bus.wdata[3:0];
          5'd7:  sd_blkcnt_o      <= bus.wdata[15:0];
          5'd8:  sd_blksize_o     <= bus.wdata[11:0];
          5'd9:  sd_cmd_timeout_o <= bus.wdata;
          5'd10: sd_drp_o         <= bus.wdata[8:0];  // dwe, den, addr
          default: ;  // 11..31 are not writable
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // read word
  ////////////////////////////////////////

  always_comb
  begin
    case (bus.reg_idx)
      SD_DETECT_IDX:    sd_rdata_o = word_t'(detect_q);
      SD_RB_BASE + 0:   sd_rdata_o = word_t'(sd_align_o);
      SD_RB_BASE + 1:   sd_rdata_o = word_t'(sd_clk_cfg_o);
      SD_RB_BASE + 2:   sd_rdata_o = sd_cmd_arg_o;
      SD_RB_BASE + 3:   sd_rdata_o = word_t'(sd_cmd_idx_o);
      SD_RB_BASE + 4:   sd_rdata_o = word_t'({sd_data_start_o, sd_cmd_setting_o});
      SD_RB_BASE + 5:   sd_rdata_o = word_t'(sd_cmd_start_o);
      SD_RB_BASE + 6:   sd_rdata_o = word_t'(sd_resets_o);
      SD_RB_BASE + 7:   sd_rdata_o = word_t'(sd_blkcnt_o);
      SD_RB_BASE + 8:   sd_rdata_o = word_t'(sd_blksize_o);
      SD_RB_BASE + 9:   sd_rdata_o = sd_cmd_timeout_o;
      SD_RB_BASE + 10:  sd_rdata_o = word_t'(sd_drp_o);
      default:          sd_rdata_o = UNMAPPED_WORD;
    endcase
  end

  // writes past the bank must leave every control field alone
  no_write_past_bank: assert property (
    @(posedge msoc_clk) disable iff (!rstn)
    bank_we && (bus.reg_idx > SD_WR_LAST) |=>
      $stable({sd_align_o, sd_clk_cfg_o, sd_cmd_arg_o, sd_cmd_idx_o,
               sd_data_start_o, sd_cmd_setting_o, sd_cmd_start_o, sd_resets_o,
               sd_blkcnt_o, sd_blksize_o, sd_cmd_timeout_o, sd_drp_o})
  ) else $error("SD register changed by write to index above bank");

endmodule

//--- source/read_mux.sv
// Registered read return
`timescale 1ns/1ps

module read_mux
  import soc_map_pkg::*;
  import periph_types_pkg::*;
(
  input  logic         msoc_clk,
  input  logic         rstn,
  periph_bus_if.reader bus,
  input  word_t        gpio_rdata_i,
  input  word_t        sd_rdata_i,
  output word_t        bus_rdata_o
);

  word_t rdata_d;

  ////////////////////////////////////////
  // slot select
  ////////////////////////////////////////

  always_comb
  begin
    rdata_d = '0;  // slots with no function read zero
    if (bus.slot_sel[SLOT_SD])
      rdata_d = sd_rdata_i;
    else if (bus.slot_sel[SLOT_GPIO])
      rdata_d = gpio_rdata_i;
  end

  // one cycle read latency, a new read every cycle
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
      bus_rdata_o <= '0;
    else
      bus_rdata_o <= rdata_d;
  end

  // the decoder always selects exactly one slot
  slot_sel_onehot: assert property (
    @(posedge msoc_clk) disable iff (!rstn) $onehot(bus.slot_sel)
  ) else $error("slot_sel not one-hot: %h", bus.slot_sel);

endmodule

//--- source/periph_top.sv
// Peripheral register top level
`timescale 1ns/1ps

module periph_top
  import periph_types_pkg::*;
(
  input  logic         msoc_clk,
  input  logic         rstn,
  // master side
  input  word_t        bus_addr_i,
  input  logic         bus_we_i,
  input  word_t        bus_wdata_i,
  output word_t        bus_rdata_o,
  // gpio and uart
  input  dip_t         dip_i,
  output led_t         led_o,
  output logic         uart_tx_start_o,
  output logic [7:0]   uart_tx_byte_o,
  output baud_t        uart_baud_o,
  // sd control
  input  logic         sd_detect_i,
  output sd_align_t    sd_align_o,
  output sd_clk_cfg_t  sd_clk_cfg_o,
  output word_t        sd_cmd_arg_o,
  output sd_cmd_idx_t  sd_cmd_idx_o,
  output sd_setting_t  sd_data_start_o,
  output sd_setting_t  sd_cmd_setting_o,
  output logic         sd_cmd_start_o,
  output sd_resets_t   sd_resets_o,
  output sd_blkcnt_t   sd_blkcnt_o,
  output sd_blksize_t  sd_blksize_o,
  output word_t        sd_cmd_timeout_o,
  output sd_drp_t      sd_drp_o
);

  word_t gpio_rdata;
  word_t sd_rdata;

  periph_bus_if bus ();

  bus_decode u_decode (
    .bus_addr_i  (bus_addr_i),
    .bus_we_i    (bus_we_i),
    .bus_wdata_i (bus_wdata_i),
    .bus         (bus.decoder)
  );

  misc_regs u_misc (
    .msoc_clk        (msoc_clk),
    .rstn            (rstn),
    .bus             (bus.target),
    .dip_i           (dip_i),
    .led_o           (led_o),
    .uart_tx_start_o (uart_tx_start_o),
    .uart_tx_byte_o  (uart_tx_byte_o),
    .uart_baud_o     (uart_baud_o),
    .gpio_rdata_o    (gpio_rdata)
  );

  sd_ctrl_regs u_sd_regs (
    .msoc_clk         (msoc_clk),
    .rstn             (rstn),
    .bus              (bus.target),
    .sd_detect_i      (sd_detect_i),
    .sd_rdata_o       (sd_rdata),
    .sd_align_o       (sd_align_o),
    .sd_clk_cfg_o     (sd_clk_cfg_o),
    .sd_cmd_arg_o     (sd_cmd_arg_o),
    .sd_cmd_idx_o     (sd_cmd_idx_o),
    .sd_data_start_o  (sd_data_start_o),
    .sd_cmd_setting_o (sd_cmd_setting_o),
    .sd_cmd_start_o   (sd_cmd_start_o),
    .sd_resets_o      (sd_resets_o),
    .sd_blkcnt_o      (sd_blkcnt_o),
    .sd_blksize_o     (sd_blksize_o),
    .sd_cmd_timeout_o (sd_cmd_timeout_o),
    .sd_drp_o         (sd_drp_o)
  );

  read_mux u_rmux (
    .msoc_clk     (msoc_clk),
    .rstn         (rstn),
    .bus          (bus.reader),
    .gpio_rdata_i (gpio_rdata),
    .sd_rdata_i   (sd_rdata),
    .bus_rdata_o  (bus_rdata_o)
  );

endmodule

//--- verif/periph_tb.sv
// Peripheral register testbench
`timescale 1ns/1ps

module periph_tb
  import soc_map_pkg::*;
  import periph_types_pkg::*;
();

  localparam int RESET_CYCLES = 5;
  // cycles per test: reset, gpio, uart, sd bank, unmapped
  localparam int TEST_CYCLES  = RESET_CYCLES + 6 + 18 + 13 + 76 + 43;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic        msoc_clk;
  logic        rstn;
  word_t       bus_addr_i;
  logic        bus_we_i;
  word_t       bus_wdata_i;
  word_t       bus_rdata_o;
  dip_t        dip_i;
  led_t        led_o;
  logic        uart_tx_start_o;
  logic [7:0]  uart_tx_byte_o;
  baud_t       uart_baud_o;
  logic        sd_detect_i;
  sd_align_t   sd_align_o;
  sd_clk_cfg_t sd_clk_cfg_o;
  word_t       sd_cmd_arg_o;
  sd_cmd_idx_t sd_cmd_idx_o;
  sd_setting_t sd_data_start_o;
  sd_setting_t sd_cmd_setting_o;
  logic        sd_cmd_start_o;
  sd_resets_t  sd_resets_o;
  sd_blkcnt_t  sd_blkcnt_o;
  sd_blksize_t sd_blksize_o;
  word_t       sd_cmd_timeout_o;
  sd_drp_t     sd_drp_o;

  periph_top uut (.*);

  ////////////////////////////////////////
  // reference state
  ////////////////////////////////////////

  integer seed = 60368;
  int     cyc = 0;        // rising edges so far
  int     err_count = 0;
  int     test_err_start;
  int     tests_run = 0;
  int     tests_failed = 0;
  word_t  sd_shadow [0:10];
  led_t   led_exp;
  logic   tx_start_exp;
  logic [7:0] tx_byte_exp;
  baud_t  baud_exp;
  dip_t   dip_seen;       // switches as the DUT sampled them
  logic   detect_seen;
  word_t  exp_data [$];   // pending read words
  word_t  exp_addr [$];
  int     exp_due [$];    // edge count at which each is checked

  always #10 msoc_clk = ~msoc_clk;

  always @(posedge msoc_clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  always @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      dip_seen    <= '0;
      detect_seen <= 1'b0;
    end
    else
    begin
      dip_seen    <= dip_i;
      detect_seen <= sd_detect_i;
    end
  end

  function automatic word_t slot_addr(input int slot, input int idx);
    return word_t'((slot << SLOT_LSB) | (idx << IDX_LSB));
  endfunction

  // bits each sd register keeps
  function automatic word_t field_mask(input int n);
    case (n)
      0:       return 32'h0000_0003;
      1, 7:    return 32'h0000_FFFF;
      3, 4:    return 32'h0000_003F;  // index 4 packs data start and setting
      5:       return 32'h0000_0001;
      6:       return 32'h0000_000F;
      8:       return 32'h0000_0FFF;
      10:      return 32'h0000_01FF;
      default: return 32'hFFFF_FFFF;  // argument and timeout
    endcase
  endfunction

  function automatic word_t predict_read(input word_t addr);
    int slot;
    int idx;
    slot = addr[23:20];
    idx  = addr[6:2];
    if (slot == SLOT_GPIO)
      return word_t'(dip_seen);
    if (slot != SLOT_SD)
      return '0;  // no readable function
    if (idx == SD_DETECT_IDX)
      return word_t'(detect_seen);
    if (idx >= SD_RB_BASE && idx <= SD_RB_BASE + SD_WR_LAST)
      return sd_shadow[idx - SD_RB_BASE];
    return 32'hDEAD_BEEF;
  endfunction

  function automatic void shadow_write(input word_t addr, input word_t data);
    int slot;
    int idx;
    slot = addr[23:20];
    idx  = addr[6:2];
    if (slot == SLOT_GPIO)
      led_exp = data[7:0];
    else if (slot == SLOT_UART && idx == 0)
    begin
      tx_byte_exp  = data[7:0];
      tx_start_exp = 1'b1;
    end
    else if (slot == SLOT_UART && idx == 1)
      baud_exp = data[15:0];
    else if (slot == SLOT_SD && idx <= 10)
      sd_shadow[idx] = data & field_mask(idx);
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic check_value(input string what, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_outputs();
    check_value("led_o", word_t'(led_o), word_t'(led_exp));
    check_value("uart_tx_start_o", word_t'(uart_tx_start_o), word_t'(tx_start_exp));
    check_value("uart_tx_byte_o", word_t'(uart_tx_byte_o), word_t'(tx_byte_exp));
    check_value("uart_baud_o", word_t'(uart_baud_o), word_t'(baud_exp));
    check_value("sd_align_o", word_t'(sd_align_o), sd_shadow[0]);
    check_value("sd_clk_cfg_o", word_t'(sd_clk_cfg_o), sd_shadow[1]);
    check_value("sd_cmd_arg_o", sd_cmd_arg_o, sd_shadow[2]);
    check_value("sd_cmd_idx_o", word_t'(sd_cmd_idx_o), sd_shadow[3]);
    check_value("sd_data_start_o", word_t'(sd_data_start_o), word_t'(sd_shadow[4][5:3]));
    check_value("sd_cmd_setting_o", word_t'(sd_cmd_setting_o), word_t'(sd_shadow[4][2:0]));
    check_value("sd_cmd_start_o", word_t'(sd_cmd_start_o), sd_shadow[5]);
    check_value("sd_resets_o", word_t'(sd_resets_o), sd_shadow[6]);
    check_value("sd_blkcnt_o", word_t'(sd_blkcnt_o), sd_shadow[7]);
    check_value("sd_blksize_o", word_t'(sd_blksize_o), sd_shadow[8]);
    check_value("sd_cmd_timeout_o", sd_cmd_timeout_o, sd_shadow[9]);
    check_value("sd_drp_o", word_t'(sd_drp_o), sd_shadow[10]);
  endtask

  // read words land one edge after their address
  always @(negedge msoc_clk)
  begin
    while (exp_due.size() > 0 && exp_due[0] == cyc)
    begin
      if (bus_rdata_o !== exp_data[0])
      begin
        $display("Fail at time %0t: read of %h returned %h, expected %h",
                 $time, exp_addr[0], bus_rdata_o, exp_data[0]);
        err_count++;
      end
      void'(exp_due.pop_front());
      void'(exp_data.pop_front());
      void'(exp_addr.pop_front());
    end
  end

  // one bus cycle, driven on the falling edge
  task automatic bus_cycle(input word_t addr, input logic we, input word_t wdata);
    @(negedge msoc_clk);
    check_outputs();  // effect of the previous cycle
    bus_addr_i  = addr;
    bus_we_i    = we;
    bus_wdata_i = wdata;
    exp_data.push_back(predict_read(addr));
    exp_addr.push_back(addr);
    exp_due.push_back(cyc + 1);
    tx_start_exp = 1'b0;
    if (we)
      shadow_write(addr, wdata);
  endtask

  task automatic flush();
    bus_cycle(slot_addr(0, 0), 1'b0, '0);
    bus_cycle(slot_addr(0, 0), 1'b0, '0);
  endtask

  task automatic start_test();
    test_err_start = err_count;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_count != test_err_start)
      tests_failed++;
    $display("%s: %0d errors", name, err_count - test_err_start);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial
  begin
    int n;
    msoc_clk = 1'b0;
    rstn = 1'b0;
    bus_addr_i = '0;
    bus_we_i = 1'b0;
    bus_wdata_i = '0;
    dip_i = '0;
    sd_detect_i = 1'b0;
    led_exp = '0;
    tx_start_exp = 1'b0;
    tx_byte_exp = '0;
    baud_exp = 16'd87;  // baud divisor after reset
    for (n = 0; n <= 10; n++)
      sd_shadow[n] = '0;
    repeat (RESET_CYCLES) @(negedge msoc_clk);
    rstn = 1'b1;

    start_test();
    check_value("bus_rdata_o", bus_rdata_o, '0);
    bus_cycle(slot_addr(0, 0), 1'b0, '0);
    bus_cycle(slot_addr(SLOT_UART, 0), 1'b0, '0);
    bus_cycle(slot_addr(SLOT_SD, SD_RB_BASE), 1'b0, '0);
    bus_cycle(slot_addr(SLOT_GPIO, 0), 1'b0, '0);
    flush();
    end_test("reset values");

    start_test();
    for (n = 0; n < 8; n++)
    begin
      bus_cycle(slot_addr(SLOT_GPIO, 0), 1'b1, $random(seed));
      dip_i = $random(seed);
      bus_cycle(slot_addr(SLOT_GPIO, 0), 1'b0, '0);
    end
    flush();
    end_test("leds and switches");

    start_test();
    for (n = 0; n < 4; n++)
    begin
      bus_cycle(slot_addr(SLOT_UART, 0), 1'b1, $random(seed));
      bus_cycle(slot_addr(0, 0), 1'b0, '0);  // strobe must drop here
    end
    bus_cycle(slot_addr(SLOT_UART, 1), 1'b1, $random(seed));
    bus_cycle(slot_addr(SLOT_UART, 1), 1'b1, $random(seed));
    bus_cycle(slot_addr(SLOT_UART, 0), 1'b0, '0);
    flush();
    end_test("uart control");

    start_test();
    repeat (3)
    begin
      for (n = 0; n <= SD_WR_LAST; n++)
        bus_cycle(slot_addr(SLOT_SD, n), 1'b1, $random(seed));
      for (n = 0; n <= SD_WR_LAST; n++)
        bus_cycle(slot_addr(SLOT_SD, SD_RB_BASE + n), 1'b0, '0);
    end
    repeat (4)
    begin
      sd_detect_i = $random(seed);
      bus_cycle(slot_addr(0, 0), 1'b0, '0);
      bus_cycle(slot_addr(SLOT_SD, SD_DETECT_IDX), 1'b0, '0);
    end
    flush();
    end_test("sd control bank");

    start_test();
    for (n = 11; n < 32; n++)
    begin
      if (n == 11 || (n >= 13 && n <= 15) || n >= 27)
        bus_cycle(slot_addr(SLOT_SD, n), 1'b0, '0);  // marker word
    end
    for (n = 0; n < N_SLOTS; n++)
    begin
      if (n != SLOT_SD && n != SLOT_GPIO)
        bus_cycle(slot_addr(n, $random(seed) & 31), 1'b0, '0);
    end
    for (n = 0; n < N_SLOTS; n++)
    begin
      if (n != SLOT_UART && n != SLOT_SD && n != SLOT_GPIO)
        bus_cycle(slot_addr(n, $random(seed) & 31), 1'b1, $random(seed));
    end
    for (n = 11; n <= 15; n++)
      bus_cycle(slot_addr(SLOT_SD, n), 1'b1, $random(seed));
    flush();
    end_test("unmapped accesses");

    $display("tests run: %0d, tests failing: %0d, errors: %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

//--- filelist.f
common/soc_map_pkg.sv
common/periph_types_pkg.sv
common/periph_bus_if.sv
source/bus_decode.sv
source/misc_regs.sv
sd_ctrl/sd_ctrl_regs.sv
source/read_mux.sv
source/periph_top.sv
verif/periph_tb.sv
